//--- common/fetch_defs.svh
// widths and cache geometry shared by the fetch front end
// line size is fixed at 16 bytes, INDEX_W may change and only the tag split moves
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// address and pc width
`define XLEN 64

// instruction width, no compressed forms
`define INSTR_W 32

// cache line and memory data width in bits
`define LINE_W 128

// byte offset bits inside one line, 16 bytes per line
`define LINE_OFFSET_W 4

// first pc after reset
`define RESET_PC 64'h0000_0000_8000_0000

// set index bits, 4 gives 16 lines
// index sits right above the line offset, tag takes the rest
`define INDEX_W 4

// cache response width, one doubleword picked by address bit 3
`define DWORD_W 64

`endif

//--- common/fetch_pkg.sv
// state types for the fetch unit and the instruction cache
// both FSMs use two-bit encodings
package fetch_pkg;

    // fetch unit FSM
    // IDLE      no request open, cpu_req may be raised here
    // WAIT_RESP one cache request open, waiting on cpu_resp
    // HOLD      instruction held for decode until id_accept
    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        WAIT_RESP = 2'b01,
        HOLD      = 2'b10
    } fetch_state_e;

    // instruction cache FSM
    // READY   takes a new request, also does the tag lookup cycle
    // REFILL  memory request held until mem_ready
    // RESPOND one cycle of cpu_resp with the selected doubleword
    typedef enum logic [1:0] {
        READY   = 2'b00,
        REFILL  = 2'b01,
        RESPOND = 2'b10
    } cache_state_e;

endpackage

//--- fetch/fetch_unit.sv
// pc register and fetch request control, one cache request open at most
// pc only moves on a redirect, a consumed pc is not fetched again
`include "fetch_defs.svh"

module fetch_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                next_pc_valid,
    input  logic                stall,
    input  logic [`XLEN-1:0]    next_pc,
    input  logic                id_accept,
    input  logic                cpu_resp,
    input  logic [`DWORD_W-1:0] cpu_rdata,
    output logic [`XLEN-1:0]    pc,
    output logic [`INSTR_W-1:0] instr,
    output logic                instr_valid,
    output logic                fetch_busy,
    output logic                cpu_req,
    output logic [`XLEN-1:0]    cpu_addr
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e state_next;

    // redirect accepted this cycle
    logic pc_load;
    // current pc still owes an instruction to decode
    logic pending;
    // open request belongs to an older pc
    logic stale;
    // good response for the current pc
    logic delivered;

    assign pc_load = next_pc_valid && !stall;

    // word aligned fetch address
    assign cpu_addr = {pc[`XLEN-1:2], 2'b00};

    assign instr_valid = (state == fetch_pkg::HOLD);

    // request raised or in flight, never while holding
    assign fetch_busy = cpu_req || (state == fetch_pkg::WAIT_RESP);

    // a redirect on the response edge also makes the data useless
    assign delivered = (state == fetch_pkg::WAIT_RESP) && cpu_resp && !stale && !pc_load;

    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::IDLE: begin
                // cache is READY whenever we sit in IDLE, so cpu_req is taken
                if (cpu_req) begin
                    state_next = fetch_pkg::WAIT_RESP;
                end
            end
            fetch_pkg::WAIT_RESP: begin
                if (cpu_resp) begin
                    state_next = delivered ? fetch_pkg::HOLD : fetch_pkg::IDLE;
                end
            end
            fetch_pkg::HOLD: begin
                // redirect drops the held word, accept hands it over
                if (pc_load || id_accept) begin
                    state_next = fetch_pkg::IDLE;
                end
            end
            default: begin
                state_next = fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= fetch_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (pc_load) begin
            pc <= next_pc;
        end
    end

    // reset pc must be fetched without a redirect
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b1;
        end else if (pc_load) begin
            pending <= 1'b1;
        end else if (delivered) begin
            pending <= 1'b0;
        end
    end

    // registered so it is low in the first cycle after reset
    // high from the edge that lands in IDLE until the request is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            cpu_req <= 1'b0;
        end else begin
            cpu_req <= (state_next == fetch_pkg::IDLE) && (pending || pc_load);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stale <= 1'b0;
        end else if (state == fetch_pkg::IDLE) begin
            // request goes out with the old pc on the redirect edge
            stale <= cpu_req && pc_load;
        end else if (state == fetch_pkg::WAIT_RESP) begin
            if (cpu_resp) begin
                stale <= 1'b0;
            end else if (pc_load) begin
                stale <= 1'b1;
            end
        end else begin
            stale <= 1'b0;
        end
    end

    // pc bit 2 picks the word inside the returned doubleword
    always_ff @(posedge clk) begin
        if (delivered) begin
            instr <= pc[2] ? cpu_rdata[`DWORD_W-1 -: `INSTR_W] : cpu_rdata[`INSTR_W-1:0];
        end
    end

endmodule

//--- icache/icache.sv
// direct-mapped read-only instruction cache, one refill open at a time
// request taken in READY, answer is one doubleword picked by address bit 3
`include "fetch_defs.svh"

module icache (
    input  logic                clk,
    input  logic                rst,
    input  logic                cpu_req,
    input  logic [`XLEN-1:0]    cpu_addr,
    input  logic                mem_ready,
    input  logic [`LINE_W-1:0]  mem_rdata,
    output logic                cpu_resp,
    output logic [`DWORD_W-1:0] cpu_rdata,
    output logic                mem_valid,
    output logic [`XLEN-1:0]    mem_addr
);

    localparam int OFFSET_W = `LINE_OFFSET_W;
    localparam int LINES    = 1 << `INDEX_W;
    // everything above index and offset
    localparam int TAG_W    = `XLEN - `INDEX_W - OFFSET_W;

    fetch_pkg::cache_state_e state;

    // lookup cycle after a request is taken, state stays READY meanwhile
    logic lookup;
    // request address, bits below 3 never matter here
    logic [`XLEN-1:3] addr_q;

    // storage
    logic [LINES-1:0]  valid;
    logic [TAG_W-1:0]  tag_mem  [LINES];
    logic [`LINE_W-1:0] data_mem [LINES];

    // fields of the registered address
    logic [`INDEX_W-1:0] index;
    logic [TAG_W-1:0]    tag;

    logic                take_req;
    logic                hit;
    logic                refill_done;
    logic [`LINE_W-1:0]  line;

    assign index = addr_q[OFFSET_W +: `INDEX_W];
    assign tag   = addr_q[`XLEN-1 -: TAG_W];

    // no new request during the lookup cycle
    assign take_req = cpu_req && (state == fetch_pkg::READY) && !lookup;

    assign hit = valid[index] && (tag_mem[index] == tag);

    assign refill_done = (state == fetch_pkg::REFILL) && mem_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= fetch_pkg::READY;
            lookup <= 1'b0;
        end else begin
            lookup <= take_req;
            case (state)
                fetch_pkg::READY: begin
                    // tag compare on the registered address
                    if (lookup) begin
                        state <= hit ? fetch_pkg::RESPOND : fetch_pkg::REFILL;
                    end
                end
                fetch_pkg::REFILL: begin
                    // line and tag are written on this same edge
                    if (mem_ready) begin
                        state <= fetch_pkg::RESPOND;
                    end
                end
                fetch_pkg::RESPOND: begin
                    state <= fetch_pkg::READY;
                end
                default: begin
                    state <= fetch_pkg::READY;
                end
            endcase
        end
    end

    // held through lookup, refill and respond
    always_ff @(posedge clk) begin
        if (take_req) begin
            addr_q <= cpu_addr[`XLEN-1:3];
        end
    end

    // all lines invalid after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (refill_done) begin
            valid[index] <= 1'b1;
        end
    end

    // a conflicting line at this index is simply overwritten
    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_mem[index]  <= tag;
            data_mem[index] <= mem_rdata;
        end
    end

    // memory request, stable until mem_ready since addr_q cannot change
    assign mem_valid = (state == fetch_pkg::REFILL);
    assign mem_addr  = {addr_q[`XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // answer always reads the array, also right after a refill
    assign line      = data_mem[index];
    assign cpu_resp  = (state == fetch_pkg::RESPOND);
    assign cpu_rdata = addr_q[3] ? line[`LINE_W-1 -: `DWORD_W] : line[`DWORD_W-1:0];

endmodule

//--- source/fetch_top.sv
// fetch front end top, fetch unit in front of the instruction cache
// memory side is a single line refill port with valid/ready
`include "fetch_defs.svh"

module fetch_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                next_pc_valid,
    input  logic                stall,
    input  logic [`XLEN-1:0]    next_pc,
    input  logic                id_accept,
    input  logic                mem_ready,
    input  logic [`LINE_W-1:0]  mem_rdata,
    output logic [`XLEN-1:0]    pc,
    output logic [`INSTR_W-1:0] instr,
    output logic                instr_valid,
    output logic                fetch_busy,
    output logic                mem_valid,
    output logic [`XLEN-1:0]    mem_addr
);

    // fetch unit to cache
    logic                cpu_req;
    logic [`XLEN-1:0]    cpu_addr;
    logic                cpu_resp;
    logic [`DWORD_W-1:0] cpu_rdata;

    fetch_unit u_fetch_unit (
        .clk           (clk),
        .rst           (rst),
        .next_pc_valid (next_pc_valid),
        .stall         (stall),
        .next_pc       (next_pc),
        .id_accept     (id_accept),
        .cpu_resp      (cpu_resp),
        .cpu_rdata     (cpu_rdata),
        .pc            (pc),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .fetch_busy    (fetch_busy),
        .cpu_req       (cpu_req),
        .cpu_addr      (cpu_addr)
    );

    icache u_icache (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_addr  (cpu_addr),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr)
    );

endmodule

//--- bench/line_memory.sv
// refill memory model, one request open at a time, answers 1 to 4 cycles after mem_valid
// word at byte address a holds a[31:0] ^ 32'h5A5A_0000, lowest address in the low bits
`include "fetch_defs.svh"

module line_memory (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_valid,
    input  logic [`XLEN-1:0]   mem_addr,
    output logic               mem_ready,
    output logic [`LINE_W-1:0] mem_rdata,
    output int                 refill_count
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DRIVE_DELAY = 2;
    localparam int WORDS       = `LINE_W / 32;

    // a request was seen and its delay is running
    logic active;
    // cycles left before mem_ready goes high
    int   wait_left;

    // whole line built from the address rule
    function automatic logic [`LINE_W-1:0] line_data(input logic [`XLEN-1:0] base);
        logic [`LINE_W-1:0] data;
        logic [`XLEN-1:0]   addr;
        data = '0;
        addr = base;
        for (int i = 0; i < WORDS; i++) begin
            data[32*i +: 32] = addr[31:0] ^ 32'h5A5A_0000;
            addr = addr + 64'd4;
        end
        return data;
    endfunction

    initial begin
        mem_ready    = 1'b0;
        mem_rdata    = '0;
        refill_count = 0;
        active       = 1'b0;
        wait_left    = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (rst) begin
                mem_ready = 1'b0;
                active    = 1'b0;
            end else if (mem_ready) begin
                // mem_valid was high across that edge too, so one refill was taken
                mem_ready    = 1'b0;
                active       = 1'b0;
                refill_count = refill_count + 1;
            end else if (mem_valid) begin
                if (!active) begin
                    active    = 1'b1;
                    wait_left = $urandom_range(4, 1);
                end else begin
                    wait_left = wait_left - 1;
                end
                // data goes out with mem_ready in the same cycle
                if (wait_left == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = line_data(mem_addr);
                end
            end
        end
    end

endmodule

//--- bench/fetch_assertions.sv
// handshake and hold rules on the fetch front end top
// sees only the top level ports, the cache handshake inside is not checked
`include "fetch_defs.svh"

module fetch_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    mem_valid,
    input logic                    mem_ready,
    input logic [`XLEN-1:0]        mem_addr,
    input logic [`INSTR_W-1:0]     instr,
    input logic                    instr_valid,
    input logic                    id_accept,
    input logic                    fetch_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // refill request may not drop or move before memory answers
    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
        else $error("memory request changed before mem_ready");

    // held word stays put until decode takes it
    instr_hold: assert property (@(posedge clk) disable iff (rst)
        instr_valid && !id_accept |=> $stable(instr))
        else $error("held instruction changed without id_accept");

    reset_clear: assert property (@(posedge clk) rst |=> !instr_valid)
        else $error("instr_valid high right after reset");

    busy_excl: assert property (@(posedge clk) disable iff (rst)
        !(fetch_busy && instr_valid))
        else $error("fetch_busy and instr_valid high together");

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
    .clk         (clk),
    .rst         (rst),
    .mem_valid   (mem_valid),
    .mem_ready   (mem_ready),
    .mem_addr    (mem_addr),
    .instr       (instr),
    .instr_valid (instr_valid),
    .id_accept   (id_accept),
    .fetch_busy  (fetch_busy)
);

//--- bench/fetch_tb.sv
// directed tests for the fetch front end with a line memory model beside it
// pc only moves on a redirect, so every test redirects and then accepts the word
`include "fetch_defs.svh"

module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_TESTS   = 6;
    localparam int TEST_CYCLES = 200;
    // enough for a stale refill and a new miss with the slowest memory
    localparam int WAIT_LIMIT  = 40;

    logic                clk;
    logic                rst;
    logic                next_pc_valid;
    logic                stall;
    logic [`XLEN-1:0]    next_pc;
    logic                id_accept;
    logic                mem_ready;
    logic [`LINE_W-1:0]  mem_rdata;
    logic [`XLEN-1:0]    pc;
    logic [`INSTR_W-1:0] instr;
    logic                instr_valid;
    logic                fetch_busy;
    logic                mem_valid;
    logic [`XLEN-1:0]    mem_addr;
    int                  refill_count;

    fetch_top u_fetch_top (
        .clk           (clk),
        .rst           (rst),
        .next_pc_valid (next_pc_valid),
        .stall         (stall),
        .next_pc       (next_pc),
        .id_accept     (id_accept),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .pc            (pc),
        .instr         (instr),
        .instr_valid   (instr_valid),
        .fetch_busy    (fetch_busy),
        .mem_valid     (mem_valid),
        .mem_addr      (mem_addr)
    );

    line_memory u_line_memory (
        .clk          (clk),
        .rst          (rst),
        .mem_valid    (mem_valid),
        .mem_addr     (mem_addr),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .refill_count (refill_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // each word holds its byte address xor a fixed pattern
    function automatic logic [`INSTR_W-1:0] expected_word(input logic [`XLEN-1:0] addr);
        return addr[31:0] ^ 32'h5A5A_0000;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("Fail %s %s: expected %h actual %h",
                               test_name, what, expected, actual));
        end
    endtask

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic redirect(input logic [`XLEN-1:0] addr);
        next_pc       = addr;
        next_pc_valid = 1'b1;
        stall         = 1'b0;
        next_cycle();
        next_pc_valid = 1'b0;
    endtask

    task automatic accept_instr();
        id_accept = 1'b1;
        next_cycle();
        id_accept = 1'b0;
    endtask

    task automatic wait_instr(input string test_name);
        int cycles;
        cycles = 0;
        while (!instr_valid && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!instr_valid) begin
            stop_run($sformatf("%s: no instruction arrived within %0d cycles",
                               test_name, WAIT_LIMIT));
        end
    endtask

    task automatic fetch_and_check(input string test_name, input logic [`XLEN-1:0] addr);
        redirect(addr);
        // fetch for the new pc is open right after the redirect edge
        check_value(test_name, "fetch_busy", 64'd1, 64'(fetch_busy));
        wait_instr(test_name);
        check_value(test_name, "pc", addr, pc);
        check_value(test_name, "instr", 64'(expected_word(addr)), 64'(instr));
        accept_instr();
    endtask

    task automatic reset_defaults();
        int refills;
        check_value("reset", "pc", `RESET_PC, pc);
        check_value("reset", "instr_valid", 64'd0, 64'(instr_valid));
        check_value("reset", "mem_valid", 64'd0, 64'(mem_valid));
        check_value("reset", "fetch_busy", 64'd0, 64'(fetch_busy));
        refills = refill_count;
        // reset pc is fetched with no redirect
        wait_instr("reset");
        check_value("reset", "instr", 64'(expected_word(`RESET_PC)), 64'(instr));
        check_value("reset", "refills", 64'(refills + 1), 64'(refill_count));
        accept_instr();
    endtask

    // one miss, then three hits covering both doublewords and both words
    task automatic line_words_in_turn();
        logic [`XLEN-1:0] addr;
        int               refills;
        addr    = `RESET_PC + 64'h40;
        refills = refill_count;
        for (int i = 0; i < 4; i++) begin
            fetch_and_check("line_words", addr);
            addr = addr + 64'd4;
        end
        check_value("line_words", "refills", 64'(refills + 1), 64'(refill_count));
    endtask

    task automatic conflict_replacement();
        logic [`XLEN-1:0] addr_a;
        logic [`XLEN-1:0] addr_b;
        int               refills;
        // same index bits 7..4, tag differs in bit 12
        addr_a  = `RESET_PC + 64'h24;
        addr_b  = addr_a + 64'h1000;
        refills = refill_count;
        fetch_and_check("conflict", addr_a);
        fetch_and_check("conflict", addr_b);
        fetch_and_check("conflict", addr_a);
        check_value("conflict", "refills", 64'(refills + 3), 64'(refill_count));
    endtask

    task automatic stall_and_hold();
        logic [`XLEN-1:0]    hold_addr;
        logic [`XLEN-1:0]    new_addr;
        logic [`INSTR_W-1:0] held;
        hold_addr = `RESET_PC + 64'h300;
        new_addr  = `RESET_PC + 64'h404;
        redirect(hold_addr);
        wait_instr("stall_hold");
        held = instr;
        check_value("stall_hold", "instr", 64'(expected_word(hold_addr)), 64'(held));
        // redirect offered while decode stalls, no accept
        next_pc       = new_addr;
        next_pc_valid = 1'b1;
        stall         = 1'b1;
        for (int i = 0; i < 3; i++) begin
            next_cycle();
            check_value("stall_hold", "pc", hold_addr, pc);
            check_value("stall_hold", "instr_valid", 64'd1, 64'(instr_valid));
            check_value("stall_hold", "instr", 64'(held), 64'(instr));
        end
        next_pc_valid = 1'b0;
        stall         = 1'b0;
        // unstalled redirect drops the held word
        redirect(new_addr);
        check_value("stall_hold", "pc", new_addr, pc);
        check_value("stall_hold", "instr_valid", 64'd0, 64'(instr_valid));
        wait_instr("stall_hold");
        check_value("stall_hold", "instr", 64'(expected_word(new_addr)), 64'(instr));
        accept_instr();
    endtask

    task automatic miss_redirect();
        logic [`XLEN-1:0] addr_a;
        logic [`XLEN-1:0] addr_b;
        int               refills;
        int               cycles;
        addr_a  = 64'h0000_0000_9000_0040;
        addr_b  = 64'h0000_0000_9000_0080;
        refills = refill_count;
        cycles  = 0;
        redirect(addr_a);
        while (!mem_valid && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (!mem_valid) begin
            stop_run("redirect_miss: refill for the first line never started");
        end
        redirect(addr_b);
        wait_instr("redirect_miss");
        check_value("redirect_miss", "pc", addr_b, pc);
        check_value("redirect_miss", "instr", 64'(expected_word(addr_b)), 64'(instr));
        // the open refill still finishes before the new line is fetched
        check_value("redirect_miss", "refills", 64'(refills + 2), 64'(refill_count));
        accept_instr();
    endtask

    // word aligned addresses inside the 4 KB window above the reset pc
    task automatic random_addresses();
        logic [`XLEN-1:0] addr;
        logic [9:0]       word_sel;
        for (int i = 0; i < 20; i++) begin
            word_sel = 10'($urandom_range(1023, 0));
            addr     = `RESET_PC + {52'd0, word_sel, 2'b00};
            fetch_and_check($sformatf("random_%0d", i), addr);
        end
    endtask

    // watchdog
    initial begin
        #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
        stop_run("timeout: the tests did not finish in time");
    end

    initial begin
        void'($urandom(31));
        rst           = 1'b1;
        next_pc_valid = 1'b0;
        stall         = 1'b0;
        next_pc       = '0;
        id_accept     = 1'b0;
        repeat (4) begin
            next_cycle();
        end
        rst = 1'b0;
        reset_defaults();
        line_words_in_turn();
        conflict_replacement();
        stall_and_hold();
        miss_redirect();
        random_addresses();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/fetch_pkg.sv
fetch/fetch_unit.sv
icache/icache.sv
source/fetch_top.sv
bench/line_memory.sv
bench/fetch_assertions.sv
bench/fetch_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the fetch front end with its testbench and run it in Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
exit 0
